// ==== access_counter.sv ====
`timescale 1ns/1ns

module access_counter import zsh_pkg::*;
(
   input  logic     aclk_i,
   input  logic     arst_n_i,
   dram_txn_if.sink txn,
   output count_t   count_o
);

   count_t count_r;

   // one increment per completed access, reads and writes alike
   always_ff @(posedge aclk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
         count_r <= '0;
      else if (!txn.acc_rst_n)
         count_r <= '0;
      else if (txn.done)
         count_r <= count_r + count_t'(1);
   end

   assign count_o = count_r;

endmodule

// ==== build.f ====
+incdir+.
zsh_pkg.sv
zsh_ifs.sv
shell_regs.sv
dram_bridge_fsm.sv
dram_addr_xlate.sv
mem_profiler.sv
access_counter.sv
zynq_shell_top.sv
zynq_shell_asserts.sv
tb_zynq_shell.sv

// ==== dram_addr_xlate.sv ====
`timescale 1ns/1ns
`include "zsh_defs.svh"

module dram_addr_xlate import zsh_pkg::*;
(
   input  logic        aclk_i,
   input  logic        arst_n_i,
   shell_ctrl_if.xlate ctrl,
   dram_txn_if.sink    txn,
   output addr_t       dram_req_addr_o
);

   addr_t flip_addr;
   logic  over_limit;
   logic  range_err_r;

   // accelerator DRAM starts at the flip base, the PS buffer starts at dram_base
   assign flip_addr       = txn.req_addr ^ `ZSH_DRAM_FLIP;
   assign dram_req_addr_o = flip_addr + txn.dram_base;
   assign over_limit      = (flip_addr >= addr_t'(`ZSH_MEM_LIMIT));

   // sticky until the PS puts the accelerator back into reset
   always_ff @(posedge aclk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
         range_err_r <= 1'b0;
      else if (!txn.acc_rst_n)
         range_err_r <= 1'b0;
      else if (txn.issue && over_limit)
         range_err_r <= 1'b1;
   end

   assign ctrl.range_err = range_err_r;

endmodule

// ==== dram_bridge_fsm.sv ====
`timescale 1ns/1ns

module dram_bridge_fsm import zsh_pkg::*;
(
   input  logic      aclk_i,
   input  logic      arst_n_i,
   shell_ctrl_if.fsm ctrl,
   dram_txn_if.src   txn,
   input  logic      acc_req_v_i,
   input  logic      acc_req_we_i,
   input  addr_t     acc_req_addr_i,
   input  data_t     acc_req_wdata_i,
   output logic      acc_req_ready_o,
   output logic      acc_resp_v_o,
   output data_t     acc_resp_data_o,
   output logic      dram_req_v_o,
   output logic      dram_req_we_o,
   output data_t     dram_req_wdata_o,
   input  logic      dram_req_ready_i,
   input  logic      dram_resp_v_i,
   input  data_t     dram_resp_data_i
);

   bridge_state_e state_r;
   bridge_state_e state_n;
   logic          accept;
   addr_t         addr_r;
   logic          we_r;
   data_t         wdata_r;
   data_t         rdata_r;

   // a new access is taken only when idle and the PS has released and allocated
   assign acc_req_ready_o = (state_r == IDLE) && ctrl.acc_rst_n && ctrl.dram_alloc;
   assign accept          = acc_req_v_i && acc_req_ready_o;

   always_comb
   begin
      state_n = state_r;
      case (state_r)
         IDLE:  if (accept)           state_n = ISSUE;
         ISSUE: if (dram_req_ready_i) state_n = WAIT;
         WAIT:  if (dram_resp_v_i)    state_n = RESP;
         RESP:                        state_n = IDLE;
         default:                     state_n = IDLE;
      endcase
      // dropping CTRL abandons whatever access is in progress
      if (!ctrl.acc_rst_n)
         state_n = IDLE;
   end

   always_ff @(posedge aclk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
         state_r <= IDLE;
      else
         state_r <= state_n;
   end

   // request fields are held for the whole access so the DRAM side sees them stable
   always_ff @(posedge aclk_i)
   begin
      if (accept)
      begin
         addr_r  <= acc_req_addr_i;
         we_r    <= acc_req_we_i;
         wdata_r <= acc_req_wdata_i;
      end
      if ((state_r == WAIT) && dram_resp_v_i)
         rdata_r <= dram_resp_data_i;
   end

   assign dram_req_v_o     = (state_r == ISSUE);
   assign dram_req_we_o    = we_r;
   assign dram_req_wdata_o = wdata_r;

   assign acc_resp_v_o    = (state_r == RESP);
   assign acc_resp_data_o = rdata_r;

   assign txn.req_addr = addr_r;
   assign txn.issue    = dram_req_v_o && dram_req_ready_i;
   assign txn.done     = acc_resp_v_o;

endmodule

// ==== mem_profiler.sv ====
`timescale 1ns/1ns
`include "zsh_defs.svh"

module mem_profiler import zsh_pkg::*;
(
   input  logic     aclk_i,
   input  logic     arst_n_i,
   dram_txn_if.sink txn,
   output prof_t    prof_o
);

   prof_t                      prof_r;
   logic [`ZSH_PROF_IDX_W-1:0] region;

   // the region is taken from the accelerator address before translation
   assign region = txn.req_addr[`ZSH_PROF_HI -: `ZSH_PROF_IDX_W];

   always_ff @(posedge aclk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
         prof_r <= '0;
      else if (!txn.acc_rst_n)
         prof_r <= '0;
      else if (txn.issue)
         prof_r[region] <= 1'b1;
   end

   assign prof_o = prof_r;

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# compile and run the shell testbench with Verilator, the log decides the result
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f build.f --top-module tb_zynq_shell \
   -o sim_zynq_shell || { echo "verilator build failed"; exit 1; }
./obj_dir/sim_zynq_shell +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -q "Simulation finished: FAIL" sim.log && { echo "run reported failure"; exit 1; }
grep -q "Simulation finished: PASS" sim.log || { echo "run ended without a result"; exit 1; }
echo "run passed"

// ==== shell_regs.sv ====
`timescale 1ns/1ns
`include "zsh_defs.svh"

module shell_regs import zsh_pkg::*;
(
   input  logic                      aclk_i,
   input  logic                      arst_n_i,
   input  logic                      ps_wr_i,
   input  logic                      ps_rd_i,
   input  logic [`ZSH_REG_IDX_W-1:0] ps_idx_i,
   input  reg_t                      ps_wdata_i,
   output reg_t                      ps_rdata_o,
   output logic                      ps_rvalid_o,
   shell_ctrl_if.regs                ctrl,
   input  count_t                    count_i,
   input  prof_t                     prof_i
);

   logic     acc_en_r;
   logic     alloc_r;
   reg_t     base_r;
   reg_t     rdata_d;
   reg_idx_e idx;

   assign idx = reg_idx_e'(ps_idx_i);

   // only CTRL, ALLOC and BASE are writable, the rest are status views
   always_ff @(posedge aclk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         acc_en_r <= 1'b0;
         alloc_r  <= 1'b0;
         base_r   <= '0;
      end
      else if (ps_wr_i)
      begin
         case (idx)
            CTRL:    acc_en_r <= ps_wdata_i[0];
            ALLOC:   alloc_r  <= ps_wdata_i[0];
            BASE:    base_r   <= ps_wdata_i;
            default: ;
         endcase
      end
   end

   assign ctrl.acc_rst_n  = acc_en_r;
   assign ctrl.dram_alloc = alloc_r;
   assign ctrl.dram_base  = base_r;

   always_comb
   begin
      case (idx)
         CTRL:     rdata_d = reg_t'(acc_en_r);
         ALLOC:    rdata_d = reg_t'(alloc_r);
         BASE:     rdata_d = base_r;
         COUNT_LO: rdata_d = count_i[`ZSH_REG_W-1:0];
         COUNT_HI: rdata_d = count_i[2*`ZSH_REG_W-1:`ZSH_REG_W];
         PROF0:    rdata_d = prof_i[0*`ZSH_REG_W +: `ZSH_REG_W];
         PROF1:    rdata_d = prof_i[1*`ZSH_REG_W +: `ZSH_REG_W];
         PROF2:    rdata_d = prof_i[2*`ZSH_REG_W +: `ZSH_REG_W];
         PROF3:    rdata_d = prof_i[3*`ZSH_REG_W +: `ZSH_REG_W];
         STATUS:   rdata_d = reg_t'(ctrl.range_err);
         default:  rdata_d = '0;
      endcase
   end

   // read data lands one cycle after the strobe
   always_ff @(posedge aclk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
         ps_rvalid_o <= 1'b0;
      else
         ps_rvalid_o <= ps_rd_i;
   end

   always_ff @(posedge aclk_i)
   begin
      if (ps_rd_i)
         ps_rdata_o <= rdata_d;
   end

endmodule

// ==== tb_zynq_shell.sv ====
`timescale 1ns/1ns
`include "zsh_defs.svh"

module tb_zynq_shell import zsh_pkg::*;
();

   localparam logic [31:0] SEED       = 32'hc912bacd;
   localparam int          NUM_TESTS  = 6;
   localparam int          NUM_ACC    = 40;
   // every test gets room for its accesses at a generous per-access budget
   localparam int          TIMEOUT_NS = NUM_TESTS * NUM_ACC * 64 * 10;

   logic                      aclk;
   logic                      arst_n;
   logic                      ps_wr;
   logic                      ps_rd;
   logic [`ZSH_REG_IDX_W-1:0] ps_idx;
   reg_t                      ps_wdata;
   reg_t                      ps_rdata;
   logic                      ps_rvalid;
   logic                      acc_rst_n;
   logic                      acc_req_v;
   logic                      acc_req_we;
   addr_t                     acc_req_addr;
   data_t                     acc_req_wdata;
   logic                      acc_req_ready;
   logic                      acc_resp_v;
   data_t                     acc_resp_data;
   logic                      dram_req_v;
   logic                      dram_req_we;
   addr_t                     dram_req_addr;
   data_t                     dram_req_wdata;
   logic                      dram_req_ready;
   logic                      dram_resp_v;
   data_t                     dram_resp_data;

   logic [31:0] rng;
   int          errors;
   int          mark;
   int          tests_failed;
   count_t      exp_count;
   prof_t       exp_prof;
   logic        exp_range;
   addr_t       base;

   zynq_shell_top i_dut (
      .aclk_i           (aclk),
      .arst_n_i         (arst_n),
      .ps_wr_i          (ps_wr),
      .ps_rd_i          (ps_rd),
      .ps_idx_i         (ps_idx),
      .ps_wdata_i       (ps_wdata),
      .ps_rdata_o       (ps_rdata),
      .ps_rvalid_o      (ps_rvalid),
      .acc_rst_n_o      (acc_rst_n),
      .acc_req_v_i      (acc_req_v),
      .acc_req_we_i     (acc_req_we),
      .acc_req_addr_i   (acc_req_addr),
      .acc_req_wdata_i  (acc_req_wdata),
      .acc_req_ready_o  (acc_req_ready),
      .acc_resp_v_o     (acc_resp_v),
      .acc_resp_data_o  (acc_resp_data),
      .dram_req_v_o     (dram_req_v),
      .dram_req_we_o    (dram_req_we),
      .dram_req_addr_o  (dram_req_addr),
      .dram_req_wdata_o (dram_req_wdata),
      .dram_req_ready_i (dram_req_ready),
      .dram_resp_v_i    (dram_resp_v),
      .dram_resp_data_i (dram_resp_data)
   );

   initial
   begin
      aclk = 1'b0;
      forever #5 aclk = ~aclk;
   end

   initial
   begin
      #(TIMEOUT_NS);
      $display("watchdog expired after %0d ns before the tests completed", TIMEOUT_NS);
      $display("Simulation finished: FAIL");
      $finish;
   end

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // the DRAM model answers with its own address and the upper half inverted
   function automatic data_t dram_word(input addr_t a);
      return {~a, a};
   endfunction

   function automatic int total_errors();
      return errors + i_dut.i_asserts.fail_cnt;
   endfunction

   task automatic next_rand(output logic [31:0] v);
      rng = xorshift(rng);
      v   = rng;
   endtask

   task automatic step();
      @(posedge aclk);
      #1;
   endtask

   task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
      assert (got === exp)
      else
      begin
         $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
         errors++;
      end
   endtask

   task automatic ps_write(input logic [3:0] idx, input reg_t data);
      ps_wr    = 1'b1;
      ps_idx   = idx;
      ps_wdata = data;
      step();
      ps_wr    = 1'b0;
   endtask

   // read data has to be there exactly one cycle after the strobe
   task automatic check_reg(input logic [3:0] idx, input reg_t exp);
      ps_rd  = 1'b1;
      ps_idx = idx;
      step();
      ps_rd  = 1'b0;
      assert (ps_rvalid)
      else
      begin
         $display("ps_rvalid_o was not high one cycle after the read of index %0d", idx);
         errors++;
      end
      check($sformatf("ps_rdata_o idx %0d", idx), 64'(ps_rdata), 64'(exp));
   endtask

   task automatic do_access(input addr_t addr, input logic we, input data_t wdata);
      logic [31:0] r;
      addr_t       exp_addr;
      exp_addr = (addr ^ `ZSH_DRAM_FLIP) + base;
      while (!acc_req_ready)
         step();
      acc_req_v     = 1'b1;
      acc_req_we    = we;
      acc_req_addr  = addr;
      acc_req_wdata = wdata;
      step();
      acc_req_v     = 1'b0;
      while (!dram_req_v)
         step();
      // DRAM stalls the request, then delays the response
      next_rand(r);
      repeat (r % 4) step();
      check("dram_req_addr_o", 64'(dram_req_addr), 64'(exp_addr));
      check("dram_req_we_o", 64'(dram_req_we), 64'(we));
      if (we)
         check("dram_req_wdata_o", dram_req_wdata, wdata);
      dram_req_ready = 1'b1;
      step();
      dram_req_ready = 1'b0;
      next_rand(r);
      repeat (r % 5) step();
      dram_resp_v    = 1'b1;
      dram_resp_data = dram_word(exp_addr);
      step();
      dram_resp_v    = 1'b0;
      while (!acc_resp_v)
         step();
      if (!we)
         check("acc_resp_data_o", acc_resp_data, dram_word(exp_addr));
      exp_count = exp_count + count_t'(1);
      exp_prof[addr[`ZSH_PROF_HI -: `ZSH_PROF_IDX_W]] = 1'b1;
      if ((addr ^ `ZSH_DRAM_FLIP) >= addr_t'(`ZSH_MEM_LIMIT))
         exp_range = 1'b1;
      step();
   endtask

   // random addresses in the accelerator DRAM window stay below the range limit
   task automatic rand_addr(output addr_t a);
      logic [31:0] r;
      next_rand(r);
      a = `ZSH_DRAM_FLIP | (r % `ZSH_MEM_LIMIT);
   endtask

   task automatic check_prof();
      for (int k = 0; k < 4; k++)
         check_reg(4'(PROF0) + 4'(k), exp_prof[k*`ZSH_REG_W +: `ZSH_REG_W]);
   endtask

   task automatic finish_test(input int num, input string name);
      int errs;
      errs = total_errors() - mark;
      if (errs != 0)
         tests_failed++;
      $display("test %0d %s: %s, %0d errors", num, name, (errs == 0) ? "ok" : "bad", errs);
      mark = total_errors();
   endtask

   initial
   begin
      logic [31:0] r;
      logic [31:0] r2;
      addr_t       a;
      rng            = SEED;
      errors         = 0;
      mark           = 0;
      tests_failed   = 0;
      exp_count      = '0;
      exp_prof       = '0;
      exp_range      = 1'b0;
      base           = '0;
      arst_n         = 1'b0;
      ps_wr          = 1'b0;
      ps_rd          = 1'b0;
      ps_idx         = '0;
      ps_wdata       = '0;
      acc_req_v      = 1'b0;
      acc_req_we     = 1'b0;
      acc_req_addr   = '0;
      acc_req_wdata  = '0;
      dram_req_ready = 1'b0;
      dram_resp_v    = 1'b0;
      dram_resp_data = '0;
      repeat (10) @(posedge aclk);
      #1 arst_n = 1'b1;

      // a request is offered before the shell is enabled and must not be taken
      acc_req_v    = 1'b1;
      acc_req_addr = `ZSH_DRAM_FLIP;
      repeat (5) step();
      check("acc_req_ready_o", 64'(acc_req_ready), 64'(0));
      ps_write(CTRL, 32'd1);
      repeat (3) step();
      check("acc_req_ready_o", 64'(acc_req_ready), 64'(0));
      check("acc_rst_n_o", 64'(acc_rst_n), 64'(1));
      acc_req_v = 1'b0;
      ps_write(ALLOC, 32'd1);
      check("acc_req_ready_o", 64'(acc_req_ready), 64'(1));
      finish_test(1, "reset and enable");

      for (int i = 0; i < NUM_ACC; i++)
      begin
         rand_addr(a);
         next_rand(r);
         next_rand(r2);
         do_access(a, 1'b1, {r, r2});
      end
      finish_test(2, "stalled writes");

      next_rand(r);
      base = r;
      ps_write(BASE, r);
      for (int i = 0; i < NUM_ACC; i++)
      begin
         rand_addr(a);
         next_rand(r);
         next_rand(r2);
         do_access(a, r[0], {r2, r});
      end
      finish_test(3, "translation and read data");

      check_reg(COUNT_LO, exp_count[`ZSH_REG_W-1:0]);
      check_reg(COUNT_HI, exp_count[2*`ZSH_REG_W-1:`ZSH_REG_W]);
      finish_test(4, "access count");

      // the last address below the limit must leave the flag clear
      do_access(`ZSH_DRAM_FLIP + addr_t'(`ZSH_MEM_LIMIT - 1), 1'b0, '0);
      check_reg(STATUS, 32'(exp_range));
      check_prof();
      do_access(`ZSH_DRAM_FLIP + addr_t'(`ZSH_MEM_LIMIT), 1'b0, '0);
      check_reg(STATUS, 32'(exp_range));
      check_prof();
      finish_test(5, "profiler and range flag");

      ps_write(CTRL, 32'd0);
      check("acc_rst_n_o", 64'(acc_rst_n), 64'(0));
      check("acc_req_ready_o", 64'(acc_req_ready), 64'(0));
      // the count, bitmap and flag clear on the edge after the CTRL bit drops
      step();
      exp_count = '0;
      exp_prof  = '0;
      check_reg(COUNT_LO, 32'd0);
      check_reg(COUNT_HI, 32'd0);
      check_prof();
      check_reg(STATUS, 32'd0);
      finish_test(6, "accelerator reset clears state");

      $display("tests %0d, failed %0d, errors %0d", NUM_TESTS, tests_failed, total_errors());
      if (total_errors() == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

// ==== zsh_defs.svh ====
`ifndef ZSH_DEFS_SVH
`define ZSH_DEFS_SVH

// bus and register widths
`define ZSH_ADDR_W      32
`define ZSH_DATA_W      64
`define ZSH_REG_W       32
`define ZSH_REG_IDX_W   4

// accelerator DRAM space starts at this base, removed by xor before the PS base is added
`define ZSH_DRAM_FLIP   32'h8000_0000

// accesses at or above this offset into the allocated buffer raise the status flag
`define ZSH_MEM_LIMIT   (120*1024*1024)

// each profiler bit covers one 8 MiB region picked by addr[29:23]
`define ZSH_PROF_BITS   128
`define ZSH_PROF_HI     29
`define ZSH_PROF_IDX_W  7

`endif

// ==== zsh_ifs.sv ====
`timescale 1ns/1ns

// control state published by the PS register block
interface shell_ctrl_if import zsh_pkg::*; ();

   logic  acc_rst_n;
   logic  dram_alloc;
   addr_t dram_base;
   logic  range_err;

   modport regs (
      output acc_rst_n,
      output dram_alloc,
      output dram_base,
      input  range_err
   );

   modport fsm (
      input  acc_rst_n,
      input  dram_alloc
   );

   modport xlate (
      output range_err
   );

endinterface

// per-access events seen by the translation, profiler and counter blocks
interface dram_txn_if import zsh_pkg::*; ();

   addr_t req_addr;
   logic  issue;
   logic  done;
   logic  acc_rst_n;
   addr_t dram_base;

   modport src (
      output req_addr,
      output issue,
      output done
   );

   modport sink (
      input  req_addr,
      input  issue,
      input  done,
      input  acc_rst_n,
      input  dram_base
   );

endinterface

// ==== zsh_pkg.sv ====
package zsh_pkg;

   `include "zsh_defs.svh"

   typedef logic [`ZSH_ADDR_W-1:0]    addr_t;
   typedef logic [`ZSH_DATA_W-1:0]    data_t;
   typedef logic [`ZSH_REG_W-1:0]     reg_t;
   typedef logic [`ZSH_PROF_BITS-1:0] prof_t;

   // the count is read back as two register words
   typedef logic [2*`ZSH_REG_W-1:0]   count_t;

   // PS register map, any index not listed reads as zero
   typedef enum logic [`ZSH_REG_IDX_W-1:0] {
      CTRL     = 4'd0,
      ALLOC    = 4'd1,
      BASE     = 4'd2,
      COUNT_LO = 4'd3,
      COUNT_HI = 4'd4,
      PROF0    = 4'd5,
      PROF1    = 4'd6,
      PROF2    = 4'd7,
      PROF3    = 4'd8,
      STATUS   = 4'd9
   } reg_idx_e;

   typedef enum logic [1:0] {
      IDLE,
      ISSUE,
      WAIT,
      RESP
   } bridge_state_e;

endpackage

// ==== zynq_shell_asserts.sv ====
`timescale 1ns/1ns
`include "zsh_defs.svh"

module zynq_shell_asserts import zsh_pkg::*;
(
   input logic                      aclk_i,
   input logic                      arst_n_i,
   input logic                      ps_wr_i,
   input logic [`ZSH_REG_IDX_W-1:0] ps_idx_i,
   input reg_t                      ps_wdata_i,
   input logic                      acc_rst_n_i,
   input logic                      acc_req_ready_i,
   input logic                      acc_resp_v_i,
   input logic                      dram_req_v_i,
   input logic                      dram_req_we_i,
   input addr_t                     dram_req_addr_i,
   input data_t                     dram_req_wdata_i,
   input logic                      dram_req_ready_i,
   input logic                      dram_resp_v_i
);

   logic alloc_r;
   logic enabled_r;
   logic pending_r;
   int   fail_cnt = 0;

   // shadow of the ALLOC bit and of the DRAM access in flight
   always_ff @(posedge aclk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         alloc_r   <= 1'b0;
         enabled_r <= 1'b0;
         pending_r <= 1'b0;
      end
      else
      begin
         if (ps_wr_i && (ps_idx_i == ALLOC))
            alloc_r <= ps_wdata_i[0];
         if (acc_rst_n_i && alloc_r)
            enabled_r <= 1'b1;
         if (dram_req_v_i && dram_req_ready_i)
            pending_r <= 1'b1;
         else if (dram_resp_v_i)
            pending_r <= 1'b0;
      end
   end

   a_ready_needs_enable: assert property (@(posedge aclk_i) disable iff (!arst_n_i)
      acc_req_ready_i |-> (acc_rst_n_i && alloc_r))
   else
   begin
      $error("acc_req_ready_o high without CTRL and ALLOC set");
      fail_cnt++;
   end

   a_quiet_before_enable: assert property (@(posedge aclk_i) disable iff (!arst_n_i)
      !enabled_r |-> (!dram_req_v_i && !acc_resp_v_i))
   else
   begin
      $error("DRAM request or response before the shell was enabled");
      fail_cnt++;
   end

   // the request has to hold still while DRAM stalls it
   a_stall_stable: assert property (@(posedge aclk_i) disable iff (!arst_n_i || !acc_rst_n_i)
      (dram_req_v_i && !dram_req_ready_i) |=> (dram_req_v_i && $stable(dram_req_addr_i)
         && $stable(dram_req_we_i) && $stable(dram_req_wdata_i)))
   else
   begin
      $error("DRAM request changed while stalled");
      fail_cnt++;
   end

   a_one_outstanding: assert property (@(posedge aclk_i) disable iff (!arst_n_i)
      dram_req_v_i |-> !pending_r)
   else
   begin
      $error("second DRAM request while one is outstanding");
      fail_cnt++;
   end

   a_resp_follows: assert property (@(posedge aclk_i) disable iff (!arst_n_i)
      dram_resp_v_i |=> acc_resp_v_i)
   else
   begin
      $error("acc_resp_v_o did not follow the DRAM response");
      fail_cnt++;
   end

   a_resp_only_after_dram: assert property (@(posedge aclk_i) disable iff (!arst_n_i)
      acc_resp_v_i |-> $past(dram_resp_v_i))
   else
   begin
      $error("acc_resp_v_o without a DRAM response one cycle earlier");
      fail_cnt++;
   end

endmodule

bind zynq_shell_top zynq_shell_asserts i_asserts (
   .aclk_i           (aclk_i),
   .arst_n_i         (arst_n_i),
   .ps_wr_i          (ps_wr_i),
   .ps_idx_i         (ps_idx_i),
   .ps_wdata_i       (ps_wdata_i),
   .acc_rst_n_i      (acc_rst_n_o),
   .acc_req_ready_i  (acc_req_ready_o),
   .acc_resp_v_i     (acc_resp_v_o),
   .dram_req_v_i     (dram_req_v_o),
   .dram_req_we_i    (dram_req_we_o),
   .dram_req_addr_i  (dram_req_addr_o),
   .dram_req_wdata_i (dram_req_wdata_o),
   .dram_req_ready_i (dram_req_ready_i),
   .dram_resp_v_i    (dram_resp_v_i)
);

// ==== zynq_shell_top.sv ====
`timescale 1ns/1ns
`include "zsh_defs.svh"

module zynq_shell_top import zsh_pkg::*;
(
   input  logic                      aclk_i,
   input  logic                      arst_n_i,
   input  logic                      ps_wr_i,
   input  logic                      ps_rd_i,
   input  logic [`ZSH_REG_IDX_W-1:0] ps_idx_i,
   input  reg_t                      ps_wdata_i,
   output reg_t                      ps_rdata_o,
   output logic                      ps_rvalid_o,
   output logic                      acc_rst_n_o,
   input  logic                      acc_req_v_i,
   input  logic                      acc_req_we_i,
   input  addr_t                     acc_req_addr_i,
   input  data_t                     acc_req_wdata_i,
   output logic                      acc_req_ready_o,
   output logic                      acc_resp_v_o,
   output data_t                     acc_resp_data_o,
   output logic                      dram_req_v_o,
   output logic                      dram_req_we_o,
   output addr_t                     dram_req_addr_o,
   output data_t                     dram_req_wdata_o,
   input  logic                      dram_req_ready_i,
   input  logic                      dram_resp_v_i,
   input  data_t                     dram_resp_data_i
);

   count_t count_w;
   prof_t  prof_w;

   shell_ctrl_if ctrl_if ();
   dram_txn_if   txn_if ();

   // the accelerator reset and the DRAM base fan out from the register block
   assign acc_rst_n_o      = ctrl_if.acc_rst_n;
   assign txn_if.acc_rst_n = ctrl_if.acc_rst_n;
   assign txn_if.dram_base = ctrl_if.dram_base;

   shell_regs i_regs (
      .aclk_i      (aclk_i),
      .arst_n_i    (arst_n_i),
      .ps_wr_i     (ps_wr_i),
      .ps_rd_i     (ps_rd_i),
      .ps_idx_i    (ps_idx_i),
      .ps_wdata_i  (ps_wdata_i),
      .ps_rdata_o  (ps_rdata_o),
      .ps_rvalid_o (ps_rvalid_o),
      .ctrl        (ctrl_if),
      .count_i     (count_w),
      .prof_i      (prof_w)
   );

   dram_bridge_fsm i_bridge (
      .aclk_i           (aclk_i),
      .arst_n_i         (arst_n_i),
      .ctrl             (ctrl_if),
      .txn              (txn_if),
      .acc_req_v_i      (acc_req_v_i),
      .acc_req_we_i     (acc_req_we_i),
      .acc_req_addr_i   (acc_req_addr_i),
      .acc_req_wdata_i  (acc_req_wdata_i),
      .acc_req_ready_o  (acc_req_ready_o),
      .acc_resp_v_o     (acc_resp_v_o),
      .acc_resp_data_o  (acc_resp_data_o),
      .dram_req_v_o     (dram_req_v_o),
      .dram_req_we_o    (dram_req_we_o),
      .dram_req_wdata_o (dram_req_wdata_o),
      .dram_req_ready_i (dram_req_ready_i),
      .dram_resp_v_i    (dram_resp_v_i),
      .dram_resp_data_i (dram_resp_data_i)
   );

   dram_addr_xlate i_xlate (
      .aclk_i          (aclk_i),
      .arst_n_i        (arst_n_i),
      .ctrl            (ctrl_if),
      .txn             (txn_if),
      .dram_req_addr_o (dram_req_addr_o)
   );

   mem_profiler i_prof (
      .aclk_i   (aclk_i),
      .arst_n_i (arst_n_i),
      .txn      (txn_if),
      .prof_o   (prof_w)
   );

   access_counter i_count (
      .aclk_i   (aclk_i),
      .arst_n_i (arst_n_i),
      .txn      (txn_if),
      .count_o  (count_w)
   );

endmodule
